// File: Makefile
TOP = tbRouterOutputPort

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing --top-module routerOutputPort -f filelist.f

clean:
	rm -rf obj_dir

// File: arbiter/grantTimer.sv
`timescale 1ns/1ps

module grantTimer #(
  parameter int LengthWidth = 12
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  flitPkg::flitType_t     flitId,
  input  logic [LengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [LengthWidth-1:0] slotLength;
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slotLength <= '0;
      count      <= '0;
    end
    else
    begin
      // every head flit reloads the slot length.
      if (flitId == flitPkg::head)
        slotLength <= length;
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == slotLength);

endmodule

// File: arbiter/portArbiter.sv
`timescale 1ns/1ps

module portArbiter #(
  parameter int LengthWidth = 12
)
(
  input  logic                          clk,
  input  logic                          rst,
  flitPortIf.sink                       ports [arbPkg::NumPorts],
  output arbPkg::grantState_t           grantState,
  output logic [arbPkg::NumPorts-1:0]   grant
);

  localparam logic [arbPkg::GrantStateWidth-1:0] StateOne = 1;

  arbPkg::grantState_t state;
  arbPkg::grantState_t nextState;
  logic [arbPkg::NumPorts-1:0] reqVec;
  logic [arbPkg::NumPorts-1:0] timesUp;
  logic [arbPkg::NumPorts-1:0] runTimer;

  // first requester among span ports, searching upward from first.
  function automatic arbPkg::grantState_t pickNext(
    input logic [arbPkg::NumPorts-1:0] reqs,
    input int unsigned first,
    input int unsigned span
  );
    arbPkg::grantState_t pick;
    int unsigned idx;
    pick = arbPkg::idle;
    for (int k = int'(span) - 1; k >= 0; k--)
    begin
      idx = first + k;
      if (idx >= arbPkg::NumPorts)
        idx = idx - arbPkg::NumPorts;
      if (reqs[idx])
        pick = arbPkg::grantState_t'(StateOne << (idx + 1));
    end
    return pick;
  endfunction

  function automatic int unsigned holderOf(input arbPkg::grantState_t s);
    int unsigned idx;
    idx = 0;
    for (int unsigned p = 0; p < arbPkg::NumPorts; p++)
    begin
      if (s[p+1])
        idx = p;
    end
    return idx;
  endfunction

  genvar i;
  generate
    for (i = 0; i < arbPkg::NumPorts; i++)
    begin : gTimer
      assign reqVec[i] = ports[i].req;

      grantTimer #(
        .LengthWidth(LengthWidth)
      ) timer_i (
        .clk(clk),
        .rst(rst),
        .flitId(ports[i].flitId),
        .length(ports[i].length),
        .runTimer(runTimer[i]),
        .timesUp(timesUp[i])
      );
    end
  endgenerate

  assign grant = state[arbPkg::NumPorts:1];

  // a holder keeps counting while its request stays and its slot lasts.
  assign runTimer = grant & reqVec & ~timesUp;

  always_comb
  begin
    nextState = arbPkg::idle;
    case (state)
      arbPkg::idle:
        nextState = pickNext(reqVec, 0, arbPkg::NumPorts);
      arbPkg::grantL, arbPkg::grantN, arbPkg::grantE, arbPkg::grantW, arbPkg::grantS:
      begin
        if (|runTimer)
          nextState = state;
        else
          nextState = pickNext(reqVec, holderOf(state) + 1, arbPkg::NumPorts - 1);
      end
      default:
        nextState = arbPkg::idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbPkg::idle;
    else
      state <= nextState;
  end

  assign grantState = state;

endmodule

// File: common/arbPkg.sv
package arbPkg;

  localparam int NumPorts = 5;

  // one state bit per port plus the idle bit.
  localparam int GrantStateWidth = NumPorts + 1;

  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } port_t;

  // one-hot, bit 0 is idle and bit p+1 grants port p.
  typedef enum logic [GrantStateWidth-1:0]
  {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } grantState_t;

endpackage

// File: common/flitPkg.sv
package flitPkg;

  // flit word layout.
  localparam int FlitWidth = 16;

  // type id sits in the top bits of the word.
  localparam int FlitIdWidth = 3;
  localparam int FlitIdLsb = FlitWidth - FlitIdWidth;

  // low bits of a head flit carry the slot length in cycles.
  localparam int LengthField = 12;

  typedef enum logic [FlitIdWidth-1:0]
  {
    none = 3'd0,
    head = 3'd1,
    body = 3'd2,
    tail = 3'd3
  } flitType_t;

  typedef logic [FlitWidth-1:0] flitWord_t;

endpackage

// File: common/flitPortIf.sv
`timescale 1ns/1ps

interface flitPortIf #(
  parameter int LengthWidth = 12
);

  logic req;
  logic valid;
  flitPkg::flitType_t flitId;
  logic [LengthWidth-1:0] length;
  flitPkg::flitWord_t flit;

  modport source
  (
    output req,
    output valid,
    output flitId,
    output length,
    output flit
  );

  modport sink
  (
    input req,
    input valid,
    input flitId,
    input length,
    input flit
  );

endinterface

// File: filelist.f
common/flitPkg.sv
common/arbPkg.sv
common/flitPortIf.sv
verilog/flitDecoder.sv
arbiter/grantTimer.sv
arbiter/portArbiter.sv
verilog/outputSwitch.sv
verilog/routerOutputPort.sv
verification/outputChecker.sv
verification/tbRouterOutputPort.sv

// File: verification/arbiter_patterns.hex
// test req valid flitL flitN flitE flitW flitS, then expected grant outValid outPort outFlit
// req, valid and grant hold one bit per port, bit 0 is L; ffff in the test column ends the list
01 00 1f 200a 200b 2003 200c 200d 00 0 0 0000
01 00 00 0000 0000 0000 0000 0000 00 0 0 0000
02 16 00 0000 0000 0000 0000 0000 00 0 0 0000
02 16 00 0000 0000 0000 0000 0000 00 0 0 0000
02 14 00 0000 0000 0000 0000 0000 02 0 0 0000
03 15 00 0000 0000 0000 0000 0000 02 0 0 0000
03 11 00 0000 0000 0000 0000 0000 04 0 0 0000
03 11 00 0000 0000 0000 0000 0000 04 0 0 0000
03 01 00 0000 0000 0000 0000 0000 10 0 0 0000
03 04 00 0000 0000 0000 0000 0000 10 0 0 0000
03 0c 04 0000 0000 2003 0000 0000 01 0 0 0000
04 0c 0c 0000 0000 4011 4031 0000 04 0 0 0000
04 0c 0c 0000 0000 4012 4032 0000 04 1 2 2003
04 0c 04 0000 0000 6013 0000 0000 04 1 2 4011
04 08 08 0000 0000 0000 200c 0000 04 1 2 4012
05 00 18 0000 0000 0000 603c 4041 08 1 2 6013
05 00 00 0000 0000 0000 0000 0000 08 1 3 200c
05 00 00 0000 0000 0000 0000 0000 00 1 3 603c
06 00 1f 4001 4002 4003 4004 4005 00 0 0 0000
06 00 00 0000 0000 0000 0000 0000 00 0 0 0000
06 00 00 0000 0000 0000 0000 0000 00 0 0 0000
ffff 00 00 0000 0000 0000 0000 0000 00 0 0 0000

// File: verification/outputChecker.sv
`timescale 1ns/1ps

module outputChecker
(
  input  logic                          clk,
  input  logic                          checkEn,
  input  logic [7:0]                    testId,
  input  logic [arbPkg::NumPorts-1:0]   grant,
  input  logic                          outValid,
  input  arbPkg::port_t                 outPort,
  input  logic [flitPkg::FlitWidth-1:0] outFlit,
  input  logic [arbPkg::NumPorts-1:0]   expGrant,
  input  logic                          expValid,
  input  logic [2:0]                    expPort,
  input  logic [flitPkg::FlitWidth-1:0] expFlit,
  output int                            errorCount
);

  int errors = 0;

  function automatic string testName(input logic [7:0] id);
    case (id)
      8'd1: return "resetIdle";
      8'd2: return "fixedOrder";
      8'd3: return "rotation";
      8'd4: return "timeSlot";
      8'd5: return "flitPath";
      8'd6: return "ungrantedDrop";
      default: return "unknown";
    endcase
  endfunction

  // outputs only move on the rising edge.
  always @(negedge clk)
  begin
    if (checkEn)
    begin
      if (grant !== expGrant)
      begin
        errors = errors + 1;
        $display("MISMATCH %s grant expected %b actual %b",
                 testName(testId), expGrant, grant);
      end
      if (outValid !== expValid)
      begin
        errors = errors + 1;
        $display("MISMATCH %s outValid expected %b actual %b",
                 testName(testId), expValid, outValid);
      end
      // port and word only mean something with a valid flit.
      if (expValid)
      begin
        if (outPort !== expPort)
        begin
          errors = errors + 1;
          $display("MISMATCH %s outPort expected %0d actual %0d",
                   testName(testId), expPort, outPort);
        end
        if (outFlit !== expFlit)
        begin
          errors = errors + 1;
          $display("MISMATCH %s outFlit expected %h actual %h",
                   testName(testId), expFlit, outFlit);
        end
      end
    end
  end

  assign errorCount = errors;

endmodule

// File: verification/tbRouterOutputPort.sv
`timescale 1ns/1ps

module tbRouterOutputPort;

  localparam int Fields = 12;
  localparam int MaxPatterns = 64;
  localparam int ResetCycles = 4;

  logic clk;
  logic rst;
  logic [arbPkg::NumPorts-1:0] reqs;
  logic [arbPkg::NumPorts-1:0] valids;
  logic [flitPkg::FlitWidth-1:0] flits [arbPkg::NumPorts];

  logic [arbPkg::NumPorts-1:0] grant;
  logic [flitPkg::FlitWidth-1:0] outFlit;
  logic outValid;
  arbPkg::port_t outPort;

  logic checkEn;
  logic [7:0] testId;
  logic [arbPkg::NumPorts-1:0] expGrant;
  logic expValid;
  logic [2:0] expPort;
  logic [flitPkg::FlitWidth-1:0] expFlit;
  int errorCount;

  logic [15:0] patterns [Fields*MaxPatterns];
  int numPatterns;
  int setupErrors = 0;
  int cycles = 0;
  int cycleLimit = 1000;

  routerOutputPort routerOutputPort_i (
    .clk(clk), .rst(rst),
    .lReq(reqs[0]), .lFlitValid(valids[0]), .lFlit(flits[0]),
    .nReq(reqs[1]), .nFlitValid(valids[1]), .nFlit(flits[1]),
    .eReq(reqs[2]), .eFlitValid(valids[2]), .eFlit(flits[2]),
    .wReq(reqs[3]), .wFlitValid(valids[3]), .wFlit(flits[3]),
    .sReq(reqs[4]), .sFlitValid(valids[4]), .sFlit(flits[4]),
    .grant(grant), .outFlit(outFlit), .outValid(outValid), .outPort(outPort)
  );

  outputChecker checker_i (
    .clk(clk), .checkEn(checkEn), .testId(testId),
    .grant(grant), .outValid(outValid), .outPort(outPort), .outFlit(outFlit),
    .expGrant(expGrant), .expValid(expValid), .expPort(expPort), .expFlit(expFlit),
    .errorCount(errorCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // one pattern line per clock cycle.
  task automatic applyPattern(input int n);
    int base;
    base = n * Fields;
    testId = patterns[base][7:0];
    reqs   = patterns[base+1][arbPkg::NumPorts-1:0];
    valids = patterns[base+2][arbPkg::NumPorts-1:0];
    for (int p = 0; p < arbPkg::NumPorts; p++)
      flits[p] = patterns[base+3+p];
    expGrant = patterns[base+8][arbPkg::NumPorts-1:0];
    expValid = patterns[base+9][0];
    expPort  = patterns[base+10][2:0];
    expFlit  = patterns[base+11];
    checkEn  = 1'b1;
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    reqs = '0;
    valids = '0;
    for (int p = 0; p < arbPkg::NumPorts; p++)
      flits[p] = '0;
    checkEn = 1'b0;
    testId = '0;
    expGrant = '0;
    expValid = 1'b0;
    expPort = '0;
    expFlit = '0;

    $readmemh("verification/arbiter_patterns.hex", patterns);
    numPatterns = 0;
    while (numPatterns < MaxPatterns && !$isunknown(patterns[numPatterns*Fields])
           && patterns[numPatterns*Fields] != 16'hffff)
      numPatterns++;
    if (numPatterns == 0)
    begin
      setupErrors++;
      $display("pattern file held no usable pattern lines");
    end
    cycleLimit = ResetCycles + numPatterns + 20;

    repeat (ResetCycles) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int n = 0; n < numPatterns; n++)
    begin
      applyPattern(n);
      @(posedge clk);
      #2;
    end
    checkEn = 1'b0;

    $display("%0d patterns, %0d mismatch errors, %0d other errors",
             numPatterns, errorCount, setupErrors);
    if (errorCount == 0 && setupErrors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: verilog/flitDecoder.sv
`timescale 1ns/1ps

module flitDecoder #(
  parameter int LengthWidth = 12
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         reqIn,
  input  logic                         flitValid,
  input  logic [flitPkg::FlitWidth-1:0] flitIn,
  flitPortIf.source                    port
);

  logic reqReg;
  logic validReg;
  flitPkg::flitWord_t flitReg;
  logic [flitPkg::LengthField-1:0] lengthField;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reqReg   <= 1'b0;
      validReg <= 1'b0;
    end
    else
    begin
      reqReg   <= reqIn;
      validReg <= flitValid;
    end
  end

  always_ff @(posedge clk)
  begin
    flitReg <= flitIn;
  end

  assign lengthField = flitReg[flitPkg::LengthField-1:0];

  assign port.req   = reqReg;
  assign port.valid = validReg;
  assign port.flit  = flitReg;

  // no valid strobe means no flit type.
  assign port.flitId = validReg
    ? flitPkg::flitType_t'(flitReg[flitPkg::FlitWidth-1:flitPkg::FlitIdLsb])
    : flitPkg::none;

  // slot counters may be narrower than the length field.
  assign port.length = lengthField[LengthWidth-1:0];

endmodule

// File: verilog/outputSwitch.sv
`timescale 1ns/1ps

module outputSwitch
(
  input  logic                          clk,
  input  logic                          rst,
  flitPortIf.sink                       ports [arbPkg::NumPorts],
  input  arbPkg::grantState_t           grantState,
  output logic [flitPkg::FlitWidth-1:0] outFlit,
  output logic                          outValid,
  output arbPkg::port_t                 outPort
);

  flitPkg::flitWord_t flits [arbPkg::NumPorts];
  logic [arbPkg::NumPorts-1:0] valids;
  arbPkg::port_t selPort;
  logic selHit;

  genvar i;
  generate
    for (i = 0; i < arbPkg::NumPorts; i++)
    begin : gTap
      assign flits[i]  = ports[i].flit;
      assign valids[i] = ports[i].valid;
    end
  endgenerate

  always_comb
  begin
    selHit  = 1'b1;
    selPort = arbPkg::portL;
    case (grantState)
      arbPkg::grantL: selPort = arbPkg::portL;
      arbPkg::grantN: selPort = arbPkg::portN;
      arbPkg::grantE: selPort = arbPkg::portE;
      arbPkg::grantW: selPort = arbPkg::portW;
      arbPkg::grantS: selPort = arbPkg::portS;
      default:        selHit  = 1'b0;
    endcase
  end

  // idle passes nothing.
  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selHit & valids[selPort];
  end

  always_ff @(posedge clk)
  begin
    outFlit <= flits[selPort];
    outPort <= selPort;
  end

endmodule

// File: verilog/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int LengthWidth = 12
)
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lReq,
  input  logic                          lFlitValid,
  input  logic [flitPkg::FlitWidth-1:0] lFlit,
  input  logic                          nReq,
  input  logic                          nFlitValid,
  input  logic [flitPkg::FlitWidth-1:0] nFlit,
  input  logic                          eReq,
  input  logic                          eFlitValid,
  input  logic [flitPkg::FlitWidth-1:0] eFlit,
  input  logic                          wReq,
  input  logic                          wFlitValid,
  input  logic [flitPkg::FlitWidth-1:0] wFlit,
  input  logic                          sReq,
  input  logic                          sFlitValid,
  input  logic [flitPkg::FlitWidth-1:0] sFlit,
  output logic [arbPkg::NumPorts-1:0]   grant,
  output logic [flitPkg::FlitWidth-1:0] outFlit,
  output logic                          outValid,
  output arbPkg::port_t                 outPort
);

  arbPkg::grantState_t grantState;

  flitPortIf #(.LengthWidth(LengthWidth)) portBus [arbPkg::NumPorts] ();

  flitDecoder #(.LengthWidth(LengthWidth)) decoderL (
    .clk(clk), .rst(rst), .reqIn(lReq), .flitValid(lFlitValid), .flitIn(lFlit),
    .port(portBus[arbPkg::portL])
  );

  flitDecoder #(.LengthWidth(LengthWidth)) decoderN (
    .clk(clk), .rst(rst), .reqIn(nReq), .flitValid(nFlitValid), .flitIn(nFlit),
    .port(portBus[arbPkg::portN])
  );

  flitDecoder #(.LengthWidth(LengthWidth)) decoderE (
    .clk(clk), .rst(rst), .reqIn(eReq), .flitValid(eFlitValid), .flitIn(eFlit),
    .port(portBus[arbPkg::portE])
  );

  flitDecoder #(.LengthWidth(LengthWidth)) decoderW (
    .clk(clk), .rst(rst), .reqIn(wReq), .flitValid(wFlitValid), .flitIn(wFlit),
    .port(portBus[arbPkg::portW])
  );

  flitDecoder #(.LengthWidth(LengthWidth)) decoderS (
    .clk(clk), .rst(rst), .reqIn(sReq), .flitValid(sFlitValid), .flitIn(sFlit),
    .port(portBus[arbPkg::portS])
  );

  portArbiter #(.LengthWidth(LengthWidth)) arbiter_i (
    .clk(clk),
    .rst(rst),
    .ports(portBus),
    .grantState(grantState),
    .grant(grant)
  );

  outputSwitch switch_i (
    .clk(clk),
    .rst(rst),
    .ports(portBus),
    .grantState(grantState),
    .outFlit(outFlit),
    .outValid(outValid),
    .outPort(outPort)
  );

endmodule
